// File: hw/wts_timing_pkg.sv
// frame schedule of the sound core
// one frame is NUM_SLOTS clocks: one playback read per channel, then the CPU slot
// CPU_SLOT must stay the last slot, the playback slots are numbered from 0

package wts_timing_pkg;

	// ----------------------------------------
	// frame layout
	// ----------------------------------------
	localparam int NUM_CH    = 5;  // playback channels
	localparam int NUM_SLOTS = 6;  // clocks per frame
	localparam int CPU_SLOT  = 5;  // memory slot owned by the CPU port

	// ----------------------------------------
	// derived widths
	// ----------------------------------------
	localparam int SLOT_W    = 3;  // holds 0 .. NUM_SLOTS-1

endpackage

// File: hw/wts_wave_pkg.sv
// data widths of the wave path
// samples are signed two's complement, outputs are offset binary around OUT_MID

package wts_wave_pkg;

	// ----------------------------------------
	// wave memory
	// ----------------------------------------
	localparam int SAMPLE_W = 8;              // signed sample
	localparam int PHASE_W  = 5;              // 32 samples per wave
	localparam int ID_W     = 3;              // wave id, one per channel
	localparam int RAM_AW   = ID_W + PHASE_W; // 256 bytes

	// ----------------------------------------
	// channel registers and outputs
	// ----------------------------------------
	localparam int VOL_W    = 4;   // volume 0 .. 15
	localparam int FREQ_W   = 12;  // frames per phase step minus one
	localparam int OUT_W    = 12;
	localparam int OUT_MID  = 2048; // silence level

	// upper address bits double as the channel number in playback slots

endpackage

// File: hw/wts_slot_arbiter.sv
// frame scheduler and wave memory arbiter
// playback slots read {slot, phase}, the last slot belongs to the CPU port

`timescale 1ns/1ps

module wts_slot_arbiter (
	input  logic                               clk,
	input  logic                               nreset,
	input  logic [wts_wave_pkg::PHASE_W-1:0]   phase_addr,
	input  logic [wts_wave_pkg::RAM_AW-1:0]    cpu_addr,
	input  logic                               write_pending,
	output logic [wts_timing_pkg::SLOT_W-1:0]  slot,
	output logic                               cpu_grant,
	output logic [wts_wave_pkg::RAM_AW-1:0]    ram_addr,
	output logic                               ram_we,
	output logic                               play_valid,
	output logic [wts_timing_pkg::SLOT_W-1:0]  play_channel
);

	// ----------------------------------------
	// slot counter
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			slot <= '0;
		end else if (slot == wts_timing_pkg::SLOT_W'(wts_timing_pkg::NUM_SLOTS - 1)) begin
			slot <= '0;
		end else begin
			slot <= slot + 1'b1;
		end
	end

	assign cpu_grant = (slot == wts_timing_pkg::SLOT_W'(wts_timing_pkg::CPU_SLOT));

	// memory address and write enable for the current owner
	assign ram_addr = cpu_grant ? cpu_addr
		: {slot[wts_wave_pkg::ID_W-1:0], phase_addr};
	assign ram_we   = cpu_grant & write_pending;

	// ram_q of the next cycle belongs to whoever owns this slot
	always_ff @(posedge clk) begin
		if (!nreset) begin
			play_valid   <= 1'b0;
			play_channel <= '0;
		end else begin
			play_valid   <= ~cpu_grant;
			play_channel <= slot;
		end
	end

	a_slot_range: assert property (@(posedge clk) disable iff (!nreset)
		slot <= wts_timing_pkg::SLOT_W'(wts_timing_pkg::CPU_SLOT));

	// the RAM output after a write is never taken as a playback sample
	a_we_in_cpu_slot: assert property (@(posedge clk) disable iff (!nreset)
		ram_we |=> !play_valid);

endmodule

// File: hw/wts_cpu_port.sv
// CPU side of the wave memory, one request held until the CPU slot
// a new strobe replaces a request that is still waiting, there is no busy flag

`timescale 1ns/1ps

module wts_cpu_port (
	input  logic                                clk,
	input  logic                                nreset,
	input  logic [wts_wave_pkg::ID_W-1:0]       sram_id,
	input  logic [wts_wave_pkg::PHASE_W-1:0]    sram_a,
	input  logic [wts_wave_pkg::SAMPLE_W-1:0]   sram_d,
	input  logic                                sram_oe,
	input  logic                                sram_we,
	input  logic                                cpu_grant,
	input  logic [wts_wave_pkg::SAMPLE_W-1:0]   ram_q,
	output logic [wts_wave_pkg::RAM_AW-1:0]     cpu_addr,
	output logic [wts_wave_pkg::SAMPLE_W-1:0]   cpu_data,
	output logic                                write_pending,
	output logic [wts_wave_pkg::SAMPLE_W-1:0]   sram_q,
	output logic                                sram_q_en
);

	logic                              read_pending;
	logic [wts_wave_pkg::ID_W-1:0]     req_id;
	logic [wts_wave_pkg::PHASE_W-1:0]  req_a;
	logic                              strobe;

	assign strobe = sram_oe | sram_we;

	// request payload, taken on any strobe
	always_ff @(posedge clk) begin
		if (strobe) begin
			req_id   <= sram_id;
			req_a    <= sram_a;
			cpu_data <= sram_d;
		end
	end

	// ----------------------------------------
	// pending flags, strobe wins over grant
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			read_pending  <= 1'b0;
			write_pending <= 1'b0;
		end else if (strobe) begin
			read_pending  <= sram_oe;
			write_pending <= sram_we;
		end else if (cpu_grant) begin
			read_pending  <= 1'b0;
			write_pending <= 1'b0;
		end
	end

	// read data leaves the RAM one cycle after the grant
	always_ff @(posedge clk) begin
		if (!nreset) begin
			sram_q_en <= 1'b0;
		end else begin
			sram_q_en <= cpu_grant & read_pending;
		end
	end

	assign cpu_addr = {req_id, req_a};
	assign sram_q   = ram_q;  // valid only with sram_q_en

	a_q_en_single: assert property (@(posedge clk) disable iff (!nreset)
		sram_q_en |=> !sram_q_en);

endmodule

// File: hw/wts_tone_generator.sv
// per-channel frequency counters and wave phase
// a channel is updated once per frame in its own slot, key_on restarts the wave

`timescale 1ns/1ps

module wts_tone_generator (
	input  logic                              clk,
	input  logic                              nreset,
	input  logic [wts_timing_pkg::SLOT_W-1:0] slot,
	input  logic [wts_timing_pkg::NUM_CH-1:0] key_on,
	input  logic [wts_wave_pkg::FREQ_W-1:0]   reg_frequency_count [wts_timing_pkg::NUM_CH],
	output logic [wts_wave_pkg::PHASE_W-1:0]  phase_addr
);

	logic [wts_wave_pkg::PHASE_W-1:0] phase [wts_timing_pkg::NUM_CH];
	logic [wts_wave_pkg::FREQ_W-1:0]  count [wts_timing_pkg::NUM_CH];
	logic                             update_en;

	assign update_en = (slot < wts_timing_pkg::SLOT_W'(wts_timing_pkg::NUM_CH));

	// ----------------------------------------
	// counter and phase of the slot's channel
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			for (int i = 0; i < wts_timing_pkg::NUM_CH; i++) begin
				phase[i] <= '0;
				count[i] <= '0;
			end
		end else if (update_en) begin
			if (key_on[slot]) begin
				phase[slot] <= '0;  // restart from offset 0
				count[slot] <= reg_frequency_count[slot];
			end else if (count[slot] == '0) begin
				count[slot] <= reg_frequency_count[slot];
				phase[slot] <= phase[slot] + 1'b1;  // wraps at 32
			end else begin
				count[slot] <= count[slot] - 1'b1;
			end
		end
	end

	// address of the sample read in this slot
	assign phase_addr = update_en ? phase[slot] : '0;

	// the CPU slot must never touch a channel
	for (genvar i = 0; i < wts_timing_pkg::NUM_CH; i++) begin : g_cpu_slot_check
		a_no_update_in_cpu_slot: assert property (@(posedge clk) disable iff (!nreset)
			slot == wts_timing_pkg::SLOT_W'(wts_timing_pkg::CPU_SLOT)
			|=> $stable(phase[i]) && $stable(count[i]));
	end

endmodule

// File: hw/wts_wave_ram.sv
// 256 x 8 wave memory, one read or write per clock
// read latency one cycle, a write returns the old contents

`timescale 1ns/1ps

module wts_wave_ram (
	input  logic                              clk,
	input  logic                              ram_we,
	input  logic [wts_wave_pkg::RAM_AW-1:0]   ram_addr,
	input  logic [wts_wave_pkg::SAMPLE_W-1:0] ram_wdata,
	output logic [wts_wave_pkg::SAMPLE_W-1:0] ram_q
);

	logic [wts_wave_pkg::SAMPLE_W-1:0] mem [2**wts_wave_pkg::RAM_AW];

	always_ff @(posedge clk) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_wdata;
		end
		ram_q <= mem[ram_addr];  // read before write
	end

endmodule

// File: hw/wts_channel_mixer.sv
// volume, panning and frame sum of the five channels
// outputs change once per frame, in the cycle without play_valid

`timescale 1ns/1ps

module wts_channel_mixer (
	input  logic                              clk,
	input  logic                              nreset,
	input  logic                              play_valid,
	input  logic [wts_timing_pkg::SLOT_W-1:0] play_channel,
	input  logic [wts_wave_pkg::SAMPLE_W-1:0] ram_q,
	input  logic [wts_wave_pkg::VOL_W-1:0]    reg_volume [wts_timing_pkg::NUM_CH],
	input  logic [1:0]                        reg_enable [wts_timing_pkg::NUM_CH],
	output logic [wts_wave_pkg::OUT_W-1:0]    left_out,
	output logic [wts_wave_pkg::OUT_W-1:0]    right_out
);

	localparam int PROD_W = wts_wave_pkg::SAMPLE_W + wts_wave_pkg::VOL_W + 1;

	logic [wts_wave_pkg::VOL_W-1:0] ch_vol;
	logic [1:0]                     ch_en;
	logic signed [PROD_W-1:0]       product;
	logic signed [PROD_W-1:0]       contrib;
	logic [wts_wave_pkg::OUT_W-1:0] left_add;
	logic [wts_wave_pkg::OUT_W-1:0] right_add;
	logic [wts_wave_pkg::OUT_W-1:0] left_sum;
	logic [wts_wave_pkg::OUT_W-1:0] right_sum;

	// ----------------------------------------
	// scale and pan
	// ----------------------------------------
	assign ch_vol  = play_valid ? reg_volume[play_channel] : '0;
	assign ch_en   = play_valid ? reg_enable[play_channel] : 2'b00;
	assign product = $signed(ram_q) * $signed({1'b0, ch_vol});
	assign contrib = product >>> wts_wave_pkg::VOL_W;  // floor of sample*vol/16

	assign left_add  = ch_en[1] ? contrib[wts_wave_pkg::OUT_W-1:0] : '0;
	assign right_add = ch_en[0] ? contrib[wts_wave_pkg::OUT_W-1:0] : '0;

	// ----------------------------------------
	// frame accumulation and output load
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			left_sum  <= '0;
			right_sum <= '0;
			left_out  <= wts_wave_pkg::OUT_W'(wts_wave_pkg::OUT_MID);
			right_out <= wts_wave_pkg::OUT_W'(wts_wave_pkg::OUT_MID);
		end else if (play_valid) begin
			left_sum  <= left_sum + left_add;
			right_sum <= right_sum + right_add;
		end else begin
			// offset binary, wraps mod 4096
			left_out  <= left_sum + wts_wave_pkg::OUT_W'(wts_wave_pkg::OUT_MID);
			right_out <= right_sum + wts_wave_pkg::OUT_W'(wts_wave_pkg::OUT_MID);
			left_sum  <= '0;
			right_sum <= '0;
		end
	end

	a_channel_range: assert property (@(posedge clk) disable iff (!nreset)
		play_valid |-> play_channel < wts_timing_pkg::SLOT_W'(wts_timing_pkg::NUM_CH));

endmodule

// File: hw/wts_sound_core.sv
// five-channel wave table sound core on one 256-byte wave memory
// CPU strobes are one-cycle pulses, read data comes back with sram_q_en

`timescale 1ns/1ps

module wts_sound_core (
	input  logic                                clk,
	input  logic                                nreset,
	input  logic [wts_timing_pkg::NUM_CH-1:0]   key_on,
	input  logic [wts_wave_pkg::FREQ_W-1:0]     reg_frequency_count [wts_timing_pkg::NUM_CH],
	input  logic [wts_wave_pkg::VOL_W-1:0]      reg_volume [wts_timing_pkg::NUM_CH],
	input  logic [1:0]                          reg_enable [wts_timing_pkg::NUM_CH],
	input  logic [wts_wave_pkg::ID_W-1:0]       sram_id,
	input  logic [wts_wave_pkg::PHASE_W-1:0]    sram_a,
	input  logic [wts_wave_pkg::SAMPLE_W-1:0]   sram_d,
	input  logic                                sram_oe,
	input  logic                                sram_we,
	output logic [wts_wave_pkg::SAMPLE_W-1:0]   sram_q,
	output logic                                sram_q_en,
	output logic [wts_wave_pkg::OUT_W-1:0]      left_out,
	output logic [wts_wave_pkg::OUT_W-1:0]      right_out
);

	logic [wts_timing_pkg::SLOT_W-1:0]  slot;
	logic                               cpu_grant;
	logic [wts_wave_pkg::RAM_AW-1:0]    ram_addr;
	logic                               ram_we;
	logic [wts_wave_pkg::SAMPLE_W-1:0]  ram_q;
	logic                               play_valid;
	logic [wts_timing_pkg::SLOT_W-1:0]  play_channel;
	logic [wts_wave_pkg::PHASE_W-1:0]   phase_addr;
	logic [wts_wave_pkg::RAM_AW-1:0]    cpu_addr;
	logic [wts_wave_pkg::SAMPLE_W-1:0]  cpu_data;
	logic                               write_pending;

	wts_slot_arbiter u_slot_arbiter (
		.clk           (clk),
		.nreset        (nreset),
		.phase_addr    (phase_addr),
		.cpu_addr      (cpu_addr),
		.write_pending (write_pending),
		.slot          (slot),
		.cpu_grant     (cpu_grant),
		.ram_addr      (ram_addr),
		.ram_we        (ram_we),
		.play_valid    (play_valid),
		.play_channel  (play_channel)
	);

	wts_cpu_port u_cpu_port (
		.clk           (clk),
		.nreset        (nreset),
		.sram_id       (sram_id),
		.sram_a        (sram_a),
		.sram_d        (sram_d),
		.sram_oe       (sram_oe),
		.sram_we       (sram_we),
		.cpu_grant     (cpu_grant),
		.ram_q         (ram_q),
		.cpu_addr      (cpu_addr),
		.cpu_data      (cpu_data),
		.write_pending (write_pending),
		.sram_q        (sram_q),
		.sram_q_en     (sram_q_en)
	);

	wts_tone_generator u_tone_generator (
		.clk                 (clk),
		.nreset              (nreset),
		.slot                (slot),
		.key_on              (key_on),
		.reg_frequency_count (reg_frequency_count),
		.phase_addr          (phase_addr)
	);

	wts_wave_ram u_wave_ram (
		.clk       (clk),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (cpu_data),
		.ram_q     (ram_q)
	);

	wts_channel_mixer u_channel_mixer (
		.clk          (clk),
		.nreset       (nreset),
		.play_valid   (play_valid),
		.play_channel (play_channel),
		.ram_q        (ram_q),
		.reg_volume   (reg_volume),
		.reg_enable   (reg_enable),
		.left_out     (left_out),
		.right_out    (right_out)
	);

endmodule

// File: tb/tb_wts_tasks.svh
// directed tests and reference rules, included inside tb_wts_sound_core
// every task starts and ends on a falling clock edge

// ----------------------------------------
// reference rules
// ----------------------------------------
function automatic integer contribution(input logic [7:0] sample, input integer vol);
	return ($signed(sample) * vol) >>> 4;  // floor of sample*vol/16
endfunction

function automatic logic [11:0] offset_binary(input integer sum);
	return 12'(sum + 2048);  // wraps mod 4096
endfunction

task automatic expect_equal(input string name, input integer expected, input integer actual);
	assert (actual === expected) else begin
		$display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
		$display("STATUS: FAIL");
		$fatal(1);
	end
endtask

// ----------------------------------------
// CPU port access
// ----------------------------------------
task automatic cpu_write(input integer id, input integer a, input logic [7:0] d);
	sram_id = 3'(id);
	sram_a  = 5'(a);
	sram_d  = d;
	sram_we = 1'b1;
	@(negedge clk);
	sram_we = 1'b0;
	repeat (7) @(negedge clk);  // CPU slot comes within 6 cycles
endtask

task automatic wait_read_data(output logic [7:0] data);
	int n;
	n = 0;
	while (sram_q_en !== 1'b1 && n < 8) begin
		@(negedge clk);
		n++;
	end
	assert (sram_q_en === 1'b1) else begin
		$display("sram_q_en did not rise within 8 cycles of a read strobe");
		$display("STATUS: FAIL");
		$fatal(1);
	end
	data = sram_q;
endtask

task automatic cpu_read(input integer id, input integer a, output logic [7:0] data);
	sram_id = 3'(id);
	sram_a  = 5'(a);
	sram_oe = 1'b1;
	@(negedge clk);
	sram_oe = 1'b0;
	wait_read_data(data);
endtask

// ----------------------------------------
// tests
// ----------------------------------------
task automatic test_reset();
	repeat (12) begin
		expect_equal("test_reset", 2048, left_out);
		expect_equal("test_reset", 2048, right_out);
		expect_equal("test_reset", 0, sram_q_en);
		@(negedge clk);
	end
endtask

task automatic test_cpu_access();
	logic [7:0] wdata [32];
	logic [7:0] rd;
	for (int i = 0; i < 32; i++) begin
		wdata[i] = 8'($random(seed));
		cpu_write(i % 5, (i * 7) % 32, wdata[i]);  // 32 distinct addresses
	end
	for (int i = 0; i < 32; i++) begin
		cpu_read(i % 5, (i * 7) % 32, rd);
		expect_equal("test_cpu_access", wdata[i], rd);
	end
	cpu_write(1, 3, 8'h5a);
	cpu_write(2, 7, 8'ha5);
	cpu_read(1, 3, rd);  // returns in slot 0, far from the next grant
	expect_equal("test_cpu_access", 8'h5a, rd);
	sram_oe = 1'b1;
	@(negedge clk);
	sram_id = 3'd2;  // second strobe replaces the first
	sram_a  = 5'd7;
	@(negedge clk);
	sram_oe = 1'b0;
	wait_read_data(rd);
	expect_equal("test_cpu_access", 8'ha5, rd);
endtask

// offset 0 of every wave, phase held there by the longest count
task automatic check_mix(input string name, input bit pan);
	logic [7:0] samp;
	integer     left;
	integer     right;
	left  = 0;
	right = 0;
	for (int c = 0; c < 5; c++) begin
		samp                   = 8'($random(seed));
		reg_volume[c]          = 4'($random(seed));
		reg_enable[c]          = pan ? 2'($random(seed)) : 2'b11;
		reg_frequency_count[c] = 12'hfff;
		cpu_write(c, 0, samp);
		if (reg_enable[c][1]) begin
			left += contribution(samp, reg_volume[c]);
		end
		if (reg_enable[c][0]) begin
			right += contribution(samp, reg_volume[c]);
		end
	end
	key_on = '1;
	repeat (12) @(negedge clk);
	key_on = '0;
	repeat (18) @(negedge clk);  // three frames
	expect_equal(name, offset_binary(left), left_out);
	expect_equal(name, offset_binary(right), right_out);
endtask

// aligns to the first change after key-on, which is offset 1
task automatic follow_wave(input string name, input integer rep, input integer frames);
	logic [11:0] prev;
	int          n;
	prev = left_out;
	n    = 0;
	while (left_out === prev && n < 40) begin
		@(negedge clk);
		n++;
	end
	assert (left_out !== prev) else begin
		$display("left_out did not change within 40 cycles in %s", name);
		$display("STATUS: FAIL");
		$fatal(1);
	end
	for (int j = 0; j < frames; j++) begin
		expect_equal(name, offset_binary(contribution(wave[(1 + j / rep) % 32], 15)), left_out);
		repeat (6) @(negedge clk);
	end
endtask

task automatic test_tone_step();
	integer base;
	base = $random(seed) & 15;
	for (int k = 0; k < 32; k++) begin
		wave[k] = 8'(base + k * 7 - 112);  // steps of 7 stay distinct after scaling
		cpu_write(0, k, wave[k]);
	end
	for (int c = 1; c < 5; c++) begin
		reg_volume[c] = '0;
		reg_enable[c] = 2'b00;
	end
	reg_volume[0]          = 4'd15;
	reg_enable[0]          = 2'b10;  // left only
	reg_frequency_count[0] = 12'd0;
	for (int rep = 1; rep <= 2; rep++) begin
		key_on[0] = 1'b1;
		repeat (18) @(negedge clk);  // output settles on offset 0
		key_on[0] = 1'b0;
		follow_wave("test_tone_step", rep, 40);
		reg_frequency_count[0] = 12'd1;
	end
endtask

task automatic test_key_on();
	reg_frequency_count[0] = 12'd0;
	key_on[0] = 1'b1;
	repeat (18) @(negedge clk);
	repeat (4) begin
		expect_equal("test_key_on", offset_binary(contribution(wave[0], 15)), left_out);
		repeat (6) @(negedge clk);
	end
	key_on[0] = 1'b0;
	follow_wave("test_key_on", 1, 3);
endtask

// File: tb/tb_wts_sound_core.sv
// testbench of the wave table sound core, directed tests with a fixed random seed
// stops at the first mismatch, a watchdog bounds the run

`timescale 1ns/1ps

module tb_wts_sound_core;

	logic        clk;
	logic        nreset;
	logic [4:0]  key_on;
	logic [11:0] reg_frequency_count [wts_timing_pkg::NUM_CH];
	logic [3:0]  reg_volume [wts_timing_pkg::NUM_CH];
	logic [1:0]  reg_enable [wts_timing_pkg::NUM_CH];
	logic [2:0]  sram_id;
	logic [4:0]  sram_a;
	logic [7:0]  sram_d;
	logic        sram_oe;
	logic        sram_we;
	logic [7:0]  sram_q;
	logic        sram_q_en;
	logic [11:0] left_out;
	logic [11:0] right_out;
	integer      seed;
	logic [7:0]  wave [32];  // channel 0 wave of the tone tests

	wts_sound_core DUT (.*);

	always #10 clk = ~clk;  // 20 ns period

	`include "tb_wts_tasks.svh"

	// tests need about 1700 cycles, limit well above that
	initial begin
		#100_000;
		$display("watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$fatal(1);
	end

	// ----------------------------------------
	// reset and test sequence
	// ----------------------------------------
	initial begin
		seed    = 32'he530_3c5c;
		clk     = 1'b0;
		nreset  = 1'b0;
		key_on  = '0;
		sram_id = '0;
		sram_a  = '0;
		sram_d  = '0;
		sram_oe = 1'b0;
		sram_we = 1'b0;
		for (int c = 0; c < wts_timing_pkg::NUM_CH; c++) begin
			reg_frequency_count[c] = '0;
			reg_volume[c]          = '0;
			reg_enable[c]          = 2'b00;  // keeps unwritten memory out of the sums
		end
		repeat (10) @(negedge clk);
		nreset = 1'b1;
		test_reset();
		test_cpu_access();
		check_mix("test_mix_volume", 1'b0);
		check_mix("test_panning", 1'b1);
		test_tone_step();
		test_key_on();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: flist.f
+incdir+tb
hw/wts_timing_pkg.sv
hw/wts_wave_pkg.sv
hw/wts_slot_arbiter.sv
hw/wts_cpu_port.sv
hw/wts_tone_generator.sv
hw/wts_wave_ram.sv
hw/wts_channel_mixer.sv
hw/wts_sound_core.sv
tb/tb_wts_sound_core.sv
